/* verilog.f */
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/mips_core.sv
test/mips_core_sva.sv
test/tb_mips_core.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module tb_mips_core -f verilog.f \
  && ./obj_dir/Vtb_mips_core 2>&1 | tee sim.log

grep -q "Finished with no errors" sim.log 2>/dev/null \
  && echo "PASS" && exit 0 \
  || echo "FAIL" && exit 1

/* test/tb_mips_core.sv */
`timescale 1ns/100ps

module tb_mips_core;

  logic                      clk;
  logic                      rst_n;
  logic [mips_pkg::xlen-1:0] pc;
  mips_pkg::instr_t          instr;
  logic                      mem_write;
  logic [mips_pkg::xlen-1:0] mem_addr;
  logic [mips_pkg::xlen-1:0] mem_wdata;
  logic [mips_pkg::xlen-1:0] mem_rdata;

  mips_pkg::instr_t imem [256];
  string            instr_tag [256];
  logic [31:0]      dmem [64];       // byte addresses 0 to 0xff
  logic [31:0]      ref_regs [32];
  logic [31:0]      ref_mem [64];
  logic [31:0]      exp_addr [$];
  logic [31:0]      exp_data [$];
  string            exp_tag [$];
  integer           seed;
  int               prog_len;
  int               first_store;
  int               exp_stalls;
  int               stall_cycles;
  int               cycle;
  int               stores_checked;
  int               check_errors;
  int               timeout_errors;
  logic [31:0]      prev_pc;

  mips_core i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ---------------------------------------------------------------------
  // memory models with combinational read
  // ---------------------------------------------------------------------
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  assign instr     = (pc < 32'd1024) ? imem[pc[9:2]] : '0;  // nops past the end
  assign mem_rdata = (mem_addr < 32'd256) ? dmem[mem_addr[7:2]] : fill_word(mem_addr);

  initial
  begin
    for (int i = 0; i < 64; i++)
      dmem[i[5:0]] = fill_word({24'd0, i[5:0], 2'b00});
    forever
    begin
      @(posedge clk);
      if (mem_write && mem_addr < 32'd256)
        dmem[mem_addr[7:2]] <= mem_wdata;
    end
  end

  // ---------------------------------------------------------------------
  // program generation
  // ---------------------------------------------------------------------
  function automatic mips_pkg::instr_t enc_r(input logic [5:0] funct,
                                             input logic [4:0] rd,
                                             input logic [4:0] rs,
                                             input logic [4:0] rt);
    mips_pkg::instr_t w;
    w.r_fields = {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
    return w;
  endfunction

  function automatic mips_pkg::instr_t enc_i(input logic [5:0] op,
                                             input logic [4:0] rt,
                                             input logic [4:0] rs,
                                             input logic [15:0] imm);
    mips_pkg::instr_t w;
    w.i_fields = {op, rs, rt, imm};
    return w;
  endfunction

  function automatic logic [4:0] reg_pick(input logic [2:0] v);
    return (v == 3'd0) ? 5'd7 : {2'b00, v};  // registers 1 to 7 only
  endfunction

  function automatic logic [5:0] funct_pick(input logic [2:0] v);
    case (v)
      3'd0:    return mips_pkg::funct_add;
      3'd1:    return mips_pkg::funct_addu;
      3'd2:    return mips_pkg::funct_sub;
      3'd3:    return mips_pkg::funct_subu;
      3'd4:    return mips_pkg::funct_and;
      3'd5:    return mips_pkg::funct_or;
      3'd6:    return mips_pkg::funct_slt;
      default: return mips_pkg::funct_sltu;
    endcase
  endfunction

  task automatic emit(input mips_pkg::instr_t w, input string tag);
    imem[prog_len[7:0]]      = w;
    instr_tag[prog_len[7:0]] = tag;
    prog_len++;
  endtask

  // sw r1..r7 to 0x80..0x98
  task automatic emit_dump(input string tag);
    for (int r = 1; r <= 7; r++)
      emit(enc_i(mips_pkg::op_sw, r[4:0], 5'd0, 16'h0080 + 16'(4 * (r - 1))), tag);
  endtask

  task automatic emit_random(input int count, input string tag);
    logic [31:0] rnd;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] offs;
    for (int n = 0; n < count; n++)
    begin
      rnd  = $random(seed);
      rd   = reg_pick(rnd[6:4]);
      rs   = reg_pick(rnd[9:7]);
      rt   = reg_pick(rnd[12:10]);
      offs = {9'd0, rnd[28:24], 2'b00};  // data words 0 to 31
      case (rnd[3:0])
        4'd8, 4'd9, 4'd10: emit(enc_i(mips_pkg::op_lw, rt, 5'd0, offs), tag);
        4'd11, 4'd12:      emit(enc_i(mips_pkg::op_sw, rt, 5'd0, offs), tag);
        4'd13:             emit(enc_i(mips_pkg::op_addi, rt, rs, rnd[31:16]), tag);
        4'd14:             emit(enc_i(mips_pkg::op_ori, rt, rs, rnd[31:16]), tag);
        4'd15:
        begin
          if (rnd[13])
            emit(enc_i(mips_pkg::op_lui, rt, 5'd0, rnd[31:16]), tag);
          else
            emit(enc_i(mips_pkg::op_addiu, rt, rs, rnd[31:16]), tag);
        end
        default:           emit(enc_r(funct_pick(rnd[2:0]), rd, rs, rt), tag);
      endcase
    end
  endtask

  task automatic build_program();
    for (int i = 0; i < 256; i++)
      imem[i[7:0]] = '0;
    prog_len = 0;
    // back-to-back dependences forward from the memory stage
    emit(enc_i(mips_pkg::op_lui, 5'd1, 5'd0, 16'h1234), "forward_mem");
    emit(enc_i(mips_pkg::op_ori, 5'd1, 5'd1, 16'h5678), "forward_mem");
    emit(enc_i(mips_pkg::op_addi, 5'd2, 5'd0, 16'hfffd), "forward_mem");
    emit(enc_r(mips_pkg::funct_add, 5'd3, 5'd1, 5'd2), "forward_mem");
    emit(enc_r(mips_pkg::funct_sub, 5'd4, 5'd3, 5'd1), "forward_mem");
    emit(enc_r(mips_pkg::funct_and, 5'd5, 5'd4, 5'd3), "forward_mem");
    emit(enc_r(mips_pkg::funct_or, 5'd6, 5'd5, 5'd2), "forward_mem");
    emit(enc_r(mips_pkg::funct_subu, 5'd7, 5'd6, 5'd1), "forward_mem");
    emit_dump("forward_mem");
    // distance two and three
    emit(enc_i(mips_pkg::op_addi, 5'd1, 5'd0, 16'h0111), "forward_wb");
    emit(enc_i(mips_pkg::op_addi, 5'd2, 5'd0, 16'h0222), "forward_wb");
    emit(enc_r(mips_pkg::funct_add, 5'd3, 5'd1, 5'd0), "forward_wb");
    emit(enc_r(mips_pkg::funct_sub, 5'd4, 5'd2, 5'd1), "forward_wb");
    emit(enc_r(mips_pkg::funct_or, 5'd5, 5'd3, 5'd2), "forward_wb");
    emit(enc_r(mips_pkg::funct_and, 5'd6, 5'd4, 5'd3), "forward_wb");
    emit(enc_r(mips_pkg::funct_addu, 5'd7, 5'd5, 5'd4), "forward_wb");
    emit_dump("forward_wb");
    // four load-use pairs
    emit(enc_i(mips_pkg::op_lw, 5'd1, 5'd0, 16'h0000), "load_use");
    emit(enc_r(mips_pkg::funct_add, 5'd2, 5'd1, 5'd1), "load_use");
    emit(enc_i(mips_pkg::op_lw, 5'd3, 5'd0, 16'h0004), "load_use");
    emit(enc_i(mips_pkg::op_sw, 5'd3, 5'd0, 16'h0010), "load_use");
    emit(enc_i(mips_pkg::op_lw, 5'd4, 5'd0, 16'h0008), "load_use");
    emit(enc_i(mips_pkg::op_addi, 5'd5, 5'd4, 16'h0001), "load_use");
    emit(enc_i(mips_pkg::op_lw, 5'd6, 5'd0, 16'h0010), "load_use");
    emit(enc_r(mips_pkg::funct_or, 5'd7, 5'd6, 5'd5), "load_use");
    emit_dump("load_use");
    // signed and unsigned corners
    emit(enc_i(mips_pkg::op_lui, 5'd1, 5'd0, 16'h8000), "edge_values");
    emit(enc_i(mips_pkg::op_addi, 5'd2, 5'd0, 16'hffff), "edge_values");
    emit(enc_i(mips_pkg::op_lui, 5'd3, 5'd0, 16'h7fff), "edge_values");
    emit(enc_i(mips_pkg::op_ori, 5'd3, 5'd3, 16'hffff), "edge_values");
    emit(enc_r(mips_pkg::funct_slt, 5'd4, 5'd1, 5'd3), "edge_values");
    emit(enc_r(mips_pkg::funct_sltu, 5'd5, 5'd1, 5'd3), "edge_values");
    emit(enc_r(mips_pkg::funct_slt, 5'd6, 5'd2, 5'd0), "edge_values");
    emit(enc_r(mips_pkg::funct_sltu, 5'd7, 5'd2, 5'd0), "edge_values");
    emit_dump("edge_values");
    emit(enc_i(mips_pkg::op_addi, 5'd4, 5'd3, 16'h0001), "edge_values");
    emit(enc_i(mips_pkg::op_addiu, 5'd5, 5'd2, 16'h8000), "edge_values");
    emit(enc_i(mips_pkg::op_ori, 5'd6, 5'd0, 16'h8000), "edge_values");
    emit(enc_r(mips_pkg::funct_sltu, 5'd7, 5'd0, 5'd2), "edge_values");
    emit(enc_r(mips_pkg::funct_slt, 5'd1, 5'd1, 5'd2), "edge_values");
    emit_dump("edge_values");
    emit_random(140, "random_program");
    emit_dump("final_dump");
  endtask

  // ---------------------------------------------------------------------
  // reference model with plain in-order ISA semantics
  // ---------------------------------------------------------------------
  function automatic logic [31:0] isa_result(input mips_pkg::instr_t w,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] sext;
    logic [31:0] zext;
    sext = {{16{w.i_fields.imm16[15]}}, w.i_fields.imm16};
    zext = {16'h0000, w.i_fields.imm16};
    if (w.r_fields.op == mips_pkg::op_rtype)
    begin
      case (w.r_fields.funct)
        mips_pkg::funct_add, mips_pkg::funct_addu: return a + b;
        mips_pkg::funct_sub, mips_pkg::funct_subu: return a - b;
        mips_pkg::funct_and:  return a & b;
        mips_pkg::funct_or:   return a | b;
        mips_pkg::funct_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        mips_pkg::funct_sltu: return (a < b) ? 32'd1 : 32'd0;
        default:              return 32'd0;
      endcase
    end
    else if (w.r_fields.op == mips_pkg::op_ori)
      return a | zext;
    else if (w.r_fields.op == mips_pkg::op_lui)
      return {w.i_fields.imm16, 16'h0000};
    else
      return a + sext;  // lw and sw address, addi, addiu
  endfunction

  function automatic logic [4:0] isa_dest(input mips_pkg::instr_t w);
    case (w.r_fields.op)
      mips_pkg::op_rtype:
      begin
        case (w.r_fields.funct)
          mips_pkg::funct_add, mips_pkg::funct_addu, mips_pkg::funct_sub,
          mips_pkg::funct_subu, mips_pkg::funct_and, mips_pkg::funct_or,
          mips_pkg::funct_slt, mips_pkg::funct_sltu: return w.r_fields.rd;
          default: return 5'd0;
        endcase
      end
      mips_pkg::op_lw, mips_pkg::op_addi, mips_pkg::op_addiu,
      mips_pkg::op_ori, mips_pkg::op_lui: return w.i_fields.rt;
      default: return 5'd0;
    endcase
  endfunction

  task automatic run_reference();
    mips_pkg::instr_t w;
    mips_pkg::instr_t nxt;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    logic [4:0]       dest;
    for (int r = 0; r < 32; r++)
      ref_regs[r[4:0]] = '0;
    for (int i = 0; i < 64; i++)
      ref_mem[i[5:0]] = fill_word({24'd0, i[5:0], 2'b00});
    first_store = -1;
    exp_stalls  = 0;
    for (int k = 0; k < prog_len; k++)
    begin
      w    = imem[k[7:0]];
      nxt  = imem[8'(k + 1)];
      a    = ref_regs[w.r_fields.rs];
      b    = ref_regs[w.r_fields.rt];
      res  = isa_result(w, a, b);
      dest = isa_dest(w);
      if (w.r_fields.op == mips_pkg::op_sw)
      begin
        ref_mem[res[7:2]] = b;
        exp_addr.push_back(res);
        exp_data.push_back(b);
        exp_tag.push_back(instr_tag[k[7:0]]);
        if (first_store < 0)
          first_store = k;
      end
      else if (w.r_fields.op == mips_pkg::op_lw)
      begin
        res = ref_mem[res[7:2]];
        // one held cycle when the next word names the load target in rs or rt
        if (dest != 5'd0 && (nxt.r_fields.rs == dest || nxt.r_fields.rt == dest))
          exp_stalls++;
      end
      if (dest != 5'd0)
        ref_regs[dest] = res;
    end
  endtask

  // ---------------------------------------------------------------------
  // compare process sampling on the falling edge
  // ---------------------------------------------------------------------
  task automatic check_store();
    logic [31:0] a;
    logic [31:0] d;
    string       tag;
    assert (cycle >= first_store + 3)
    else
    begin
      $display("store seen in cycle %0d, before the first store could reach memory", cycle);
      check_errors++;
    end
    if (exp_addr.size() == 0)
    begin
      $display("unexpected store of %h to %h, no more stores were expected", mem_wdata,
               mem_addr);
      check_errors++;
    end
    else
    begin
      a   = exp_addr.pop_front();
      d   = exp_data.pop_front();
      tag = exp_tag.pop_front();
      assert (mem_addr == a)
      else
      begin
        $display("CHECK FAILED %s store address: expected %h actual %h", tag, a, mem_addr);
        check_errors++;
      end
      assert (mem_wdata == d)
      else
      begin
        $display("CHECK FAILED %s store data: expected %h actual %h", tag, d, mem_wdata);
        check_errors++;
      end
      stores_checked++;
    end
  endtask

  initial
  begin
    cycle        = 0;
    stall_cycles = 0;
    prev_pc      = '0;
    forever
    begin
      @(negedge clk);
      if (rst_n)
      begin
        if (cycle == 0)
        begin
          assert (pc == 32'd0)
          else
          begin
            $display("CHECK FAILED reset_pc: expected %h actual %h", 32'd0, pc);
            check_errors++;
          end
        end
        if (cycle > 0 && pc == prev_pc)
          stall_cycles++;  // held pc marks a load-use stall
        prev_pc = pc;
        if (mem_write)
          check_store();
        cycle++;
      end
    end
  end

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial
  begin
    int          guard;
    logic [31:0] end_pc;
    rst_n          = 1'b0;
    seed           = 32'ha968d086;
    check_errors   = 0;
    timeout_errors = 0;
    stores_checked = 0;
    build_program();
    run_reference();
    end_pc = 32'(prog_len * 4);

    for (int c = 0; c < 16; c++)
    begin
      @(negedge clk);
      assert (pc == 32'd0 && !mem_write)
      else
      begin
        $display("pc or mem_write not cleared during reset, pc %h", pc);
        check_errors++;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;

    guard = 0;
    while (exp_addr.size() != 0 && guard < 2000)
    begin
      @(negedge clk);
      guard++;
    end
    if (exp_addr.size() != 0)
    begin
      $display("timeout with %0d expected stores still missing", exp_addr.size());
      timeout_errors++;
    end

    // let the pipeline run well past the program end
    guard = 0;
    while (pc < end_pc + 32'd128 && guard < 2000)
    begin
      @(negedge clk);
      guard++;
    end
    if (pc < end_pc + 32'd128)
    begin
      $display("timeout while the pipeline drained, pc stuck at %h", pc);
      timeout_errors++;
    end

    assert (stall_cycles == exp_stalls)
    else
    begin
      $display("CHECK FAILED load_use_stalls: expected %0d actual %0d", exp_stalls,
               stall_cycles);
      check_errors++;
    end

    $display("stores checked: %0d, check errors: %0d, timeout errors: %0d", stores_checked,
             check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* test/mips_core_sva.sv */
`timescale 1ns/100ps

module mips_core_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      stall,
  input logic                      mem_write,
  input logic [mips_pkg::xlen-1:0] pc
);

  // ---------------------------------------------------------------------
  // reset
  // ---------------------------------------------------------------------
  no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_write)
    else $error("mem_write went high while rst_n was low");

  // ---------------------------------------------------------------------
  // pc only holds or steps, no branches left
  // ---------------------------------------------------------------------
  pc_holds_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (rst_n && stall) |=> (pc == $past(pc)))
    else $error("pc moved in a load-use stall cycle");

  pc_steps_by_four: assert property (@(posedge clk) disable iff (!rst_n)
    (rst_n && !stall) |=> (pc == $past(pc) + 32'd4))  // rst_n term skips the release edge
    else $error("pc did not advance by four outside a stall");

endmodule

bind mips_core mips_core_sva i_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .stall     (stall),
  .mem_write (mem_write),
  .pc        (pc)
);

/* hdl/mips_core.sv */
`timescale 1ns/100ps

module mips_core (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic [mips_pkg::xlen-1:0]  pc,
  input  mips_pkg::instr_t           instr,
  output logic                       mem_write,
  output logic [mips_pkg::xlen-1:0]  mem_addr,
  output logic [mips_pkg::xlen-1:0]  mem_wdata,
  input  logic [mips_pkg::xlen-1:0]  mem_rdata
);

  logic                            stall;
  mips_pkg::instr_t                id_instr;
  mips_pkg::ctrl_t                 ctrl;
  logic [mips_pkg::xlen-1:0]       rd1;
  logic [mips_pkg::xlen-1:0]       rd2;
  mips_pkg::fwd_sel_t              fwd_a;
  mips_pkg::fwd_sel_t              fwd_b;
  mips_pkg::id_ex_t                id_ex;
  mips_pkg::ex_mem_t               ex_mem;
  mips_pkg::mem_wb_t               mem_wb;
  logic                            wb_we;
  logic [mips_pkg::reg_addr_w-1:0] wb_addr;
  logic [mips_pkg::xlen-1:0]       wb_result;

  // data port straight off the memory stage
  assign mem_write = ex_mem.mem_write;
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;

  // ---------------------------------------------------------------------
  fetch_stage i_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .instr    (instr),
    .pc       (pc),
    .id_instr (id_instr)
  );

  decode_unit i_decode (
    .id_instr (id_instr),
    .ctrl     (ctrl)
  );

  register_file i_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_instr (id_instr),
    .wb_we    (wb_we),
    .wb_addr  (wb_addr),
    .wb_data  (wb_result),
    .rd1      (rd1),
    .rd2      (rd2)
  );

  hazard_unit i_hazard (
    .id_instr (id_instr),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .stall    (stall),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b)
  );

  execute_stage i_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .id_instr  (id_instr),
    .ctrl      (ctrl),
    .rd1       (rd1),
    .rd2       (rd2),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b),
    .wb_result (wb_result),
    .id_ex     (id_ex),
    .ex_mem    (ex_mem)
  );

  writeback_stage i_writeback (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_mem    (ex_mem),
    .mem_rdata (mem_rdata),
    .mem_wb    (mem_wb),
    .wb_we     (wb_we),
    .wb_addr   (wb_addr),
    .wb_result (wb_result)
  );

endmodule

/* hdl/writeback_stage.sv */
`timescale 1ns/100ps

module writeback_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mips_pkg::ex_mem_t               ex_mem,
  input  logic [mips_pkg::xlen-1:0]       mem_rdata,
  output mips_pkg::mem_wb_t               mem_wb,
  output logic                            wb_we,
  output logic [mips_pkg::reg_addr_w-1:0] wb_addr,
  output logic [mips_pkg::xlen-1:0]       wb_result
);

  mips_pkg::mem_wb_t mem_wb_next;

  // memory is combinational, read data sampled at the same edge
  always_comb
  begin
    mem_wb_next.reg_write  = ex_mem.reg_write;
    mem_wb_next.mem_to_reg = ex_mem.mem_to_reg;
    mem_wb_next.dest       = ex_mem.dest;
    mem_wb_next.alu_result = ex_mem.alu_result;
    mem_wb_next.load_data  = mem_rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mem_wb <= '0;
    else
      mem_wb <= mem_wb_next;
  end

  // ---------------------------------------------------------------------
  // register write port, also the late forward source
  // ---------------------------------------------------------------------
  assign wb_we     = mem_wb.reg_write;
  assign wb_addr   = mem_wb.dest;
  assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  mips_pkg::instr_t          id_instr,
  input  mips_pkg::ctrl_t           ctrl,
  input  logic [mips_pkg::xlen-1:0] rd1,
  input  logic [mips_pkg::xlen-1:0] rd2,
  input  mips_pkg::fwd_sel_t        fwd_a,
  input  mips_pkg::fwd_sel_t        fwd_b,
  input  logic [mips_pkg::xlen-1:0] wb_result,
  output mips_pkg::id_ex_t          id_ex,
  output mips_pkg::ex_mem_t         ex_mem
);

  mips_pkg::id_ex_t          id_ex_next;
  mips_pkg::ex_mem_t         ex_mem_next;
  logic [mips_pkg::xlen-1:0] imm_ext;
  logic [mips_pkg::xlen-1:0] imm_val;
  logic [mips_pkg::xlen-1:0] fwd_rs;
  logic [mips_pkg::xlen-1:0] fwd_rt;
  logic [mips_pkg::xlen-1:0] alu_a;
  logic [mips_pkg::xlen-1:0] alu_b;
  logic [mips_pkg::xlen-1:0] alu_y;

  function automatic logic [mips_pkg::xlen-1:0] fwd_mux(
    input mips_pkg::fwd_sel_t        sel,
    input logic [mips_pkg::xlen-1:0] reg_val,
    input logic [mips_pkg::xlen-1:0] mem_val,
    input logic [mips_pkg::xlen-1:0] wb_val
  );
    case (sel)
      mips_pkg::fwd_from_mem: return mem_val;
      mips_pkg::fwd_from_wb:  return wb_val;
      default:                return reg_val;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // decode to execute register
  // ---------------------------------------------------------------------
  always_comb
  begin
    id_ex_next.ctrl = ctrl;
    id_ex_next.rs   = id_instr.r_fields.rs;
    id_ex_next.rt   = id_instr.r_fields.rt;
    id_ex_next.dest = ctrl.reg_dst_rd ? id_instr.r_fields.rd : id_instr.r_fields.rt;
    id_ex_next.rd1  = rd1;
    id_ex_next.rd2  = rd2;
    id_ex_next.imm  = id_instr.i_fields.imm16;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      id_ex <= '0;
    else if (stall)
      id_ex <= '0;  // bubble, decode holds its instruction
    else
      id_ex <= id_ex_next;
  end

  // immediate shaping
  assign imm_ext = id_ex.ctrl.sign_ext ? {{16{id_ex.imm[15]}}, id_ex.imm}
                                       : {16'h0000, id_ex.imm};
  assign imm_val = id_ex.ctrl.imm_upper ? {id_ex.imm, 16'h0000} : imm_ext;

  assign fwd_rs = fwd_mux(fwd_a, id_ex.rd1, ex_mem.alu_result, wb_result);
  assign fwd_rt = fwd_mux(fwd_b, id_ex.rd2, ex_mem.alu_result, wb_result);

  assign alu_a = id_ex.ctrl.imm_upper ? '0 : fwd_rs;  // lui ignores rs
  assign alu_b = id_ex.ctrl.alu_src_imm ? imm_val : fwd_rt;

  // ---------------------------------------------------------------------
  // ALU
  // ---------------------------------------------------------------------
  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      mips_pkg::alu_sub:  alu_y = alu_a - alu_b;
      mips_pkg::alu_and:  alu_y = alu_a & alu_b;
      mips_pkg::alu_or:   alu_y = alu_a | alu_b;
      mips_pkg::alu_slt:  alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
      mips_pkg::alu_sltu: alu_y = {31'd0, alu_a < alu_b};
      default:            alu_y = alu_a + alu_b;
    endcase
  end

  always_comb
  begin
    ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_next.mem_to_reg = id_ex.ctrl.mem_to_reg;
    ex_mem_next.mem_write  = id_ex.ctrl.mem_write;
    ex_mem_next.dest       = id_ex.dest;
    ex_mem_next.alu_result = alu_y;
    ex_mem_next.store_data = fwd_rt;  // sw data, forwarded rt
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ex_mem <= '0;
    else
      ex_mem <= ex_mem_next;
  end

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
  input  mips_pkg::instr_t   id_instr,
  input  mips_pkg::id_ex_t   id_ex,
  input  mips_pkg::ex_mem_t  ex_mem,
  input  mips_pkg::mem_wb_t  mem_wb,
  output logic               stall,
  output mips_pkg::fwd_sel_t fwd_a,
  output mips_pkg::fwd_sel_t fwd_b
);

  logic load_in_ex;

  // ---------------------------------------------------------------------
  // load-use stall
  // ---------------------------------------------------------------------
  // load data only exists after the memory stage, so one bubble is needed
  assign load_in_ex = id_ex.ctrl.mem_to_reg && (id_ex.dest != '0);

  assign stall = load_in_ex &&
                 ((id_ex.dest == id_instr.r_fields.rs) ||
                  (id_ex.dest == id_instr.r_fields.rt));

  // ---------------------------------------------------------------------
  // forwarding into execute
  // ---------------------------------------------------------------------
  function automatic mips_pkg::fwd_sel_t fwd_select(
    input logic [mips_pkg::reg_addr_w-1:0] src,
    input mips_pkg::ex_mem_t               em,
    input mips_pkg::mem_wb_t               mw
  );
    // memory stage is younger so it wins
    if (em.reg_write && (em.dest != '0) && (em.dest == src))
      return mips_pkg::fwd_from_mem;
    else if (mw.reg_write && (mw.dest != '0) && (mw.dest == src))
      return mips_pkg::fwd_from_wb;
    else
      return mips_pkg::fwd_none;
  endfunction

  assign fwd_a = fwd_select(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b = fwd_select(id_ex.rt, ex_mem, mem_wb);  // also feeds store data

endmodule

/* hdl/register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mips_pkg::instr_t                id_instr,
  input  logic                            wb_we,
  input  logic [mips_pkg::reg_addr_w-1:0] wb_addr,
  input  logic [mips_pkg::xlen-1:0]       wb_data,
  output logic [mips_pkg::xlen-1:0]       rd1,
  output logic [mips_pkg::xlen-1:0]       rd2
);

  logic [mips_pkg::xlen-1:0] regs [mips_pkg::reg_count];

  // r0 hardwired, same-cycle write passes straight through
  function automatic logic [mips_pkg::xlen-1:0] read_port(
    input logic [mips_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0)
      return '0;
    else if (wb_we && (wb_addr == addr))
      return wb_data;
    else
      return regs[addr];
  endfunction

  assign rd1 = read_port(id_instr.r_fields.rs);
  assign rd2 = read_port(id_instr.r_fields.rt);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < mips_pkg::reg_count; i++)
        regs[i] <= '0;
    end
    else if (wb_we && (wb_addr != '0))
    begin
      regs[wb_addr] <= wb_data;
    end
  end

endmodule

/* hdl/decode_unit.sv */
`timescale 1ns/100ps

module decode_unit (
  input  mips_pkg::instr_t id_instr,
  output mips_pkg::ctrl_t  ctrl
);

  logic [5:0] op;
  logic [5:0] funct;

  assign op    = id_instr.r_fields.op;
  assign funct = id_instr.r_fields.funct;

  always_comb
  begin
    ctrl = '0;  // anything unknown is a nop
    case (op)
      mips_pkg::op_rtype:
      begin
        case (funct)
          mips_pkg::funct_add,
          mips_pkg::funct_addu:
          begin
            ctrl.alu_op = mips_pkg::alu_add;  // no overflow trap either way
          end
          mips_pkg::funct_sub,
          mips_pkg::funct_subu:
          begin
            ctrl.alu_op = mips_pkg::alu_sub;
          end
          mips_pkg::funct_and:  ctrl.alu_op = mips_pkg::alu_and;
          mips_pkg::funct_or:   ctrl.alu_op = mips_pkg::alu_or;
          mips_pkg::funct_slt:  ctrl.alu_op = mips_pkg::alu_slt;
          mips_pkg::funct_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
          default:              ctrl.alu_op = mips_pkg::alu_add;
        endcase
        // write only for a known function code
        case (funct)
          mips_pkg::funct_add, mips_pkg::funct_addu,
          mips_pkg::funct_sub, mips_pkg::funct_subu,
          mips_pkg::funct_and, mips_pkg::funct_or,
          mips_pkg::funct_slt, mips_pkg::funct_sltu:
          begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
          end
          default:
          begin
            ctrl.reg_write  = 1'b0;
            ctrl.reg_dst_rd = 1'b0;
          end
        endcase
      end
      mips_pkg::op_lw:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
      end
      mips_pkg::op_sw:
      begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
      end
      mips_pkg::op_addi,
      mips_pkg::op_addiu:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
      end
      mips_pkg::op_ori:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;  // zero extended
        ctrl.alu_op      = mips_pkg::alu_or;
      end
      mips_pkg::op_lui:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.imm_upper   = 1'b1;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  mips_pkg::instr_t          instr,
  output logic [mips_pkg::xlen-1:0] pc,
  output mips_pkg::instr_t          id_instr
);

  logic [mips_pkg::xlen-1:0] pc_plus4;

  assign pc_plus4 = pc + mips_pkg::xlen'(4);  // no branches, only step or hold

  // program counter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc <= '0;
    end
    else if (!stall)
    begin
      pc <= pc_plus4;
    end
  end

  // ---------------------------------------------------------------------
  // fetch to decode register
  // ---------------------------------------------------------------------
  // reset value is sll r0,r0,0 which decodes as a nop
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_instr <= '0;
    end
    else if (!stall)
    begin
      id_instr <= instr;  // held while load-use stall
    end
  end

endmodule

/* hdl/mips_pkg.sv */
package mips_pkg;

  // ---------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;

  // main opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'b000000;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sw    = 6'b101011;
  localparam logic [5:0] op_addi  = 6'b001000;
  localparam logic [5:0] op_addiu = 6'b001001;
  localparam logic [5:0] op_ori   = 6'b001101;
  localparam logic [5:0] op_lui   = 6'b001111;

  // function codes, r-type only
  localparam logic [5:0] funct_add  = 6'b100000;
  localparam logic [5:0] funct_addu = 6'b100001;
  localparam logic [5:0] funct_sub  = 6'b100010;
  localparam logic [5:0] funct_subu = 6'b100011;
  localparam logic [5:0] funct_and  = 6'b100100;
  localparam logic [5:0] funct_or   = 6'b100101;
  localparam logic [5:0] funct_slt  = 6'b101010;
  localparam logic [5:0] funct_sltu = 6'b101011;

  typedef enum logic [2:0] {
    alu_add,  // zero control word lands here
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_sltu
  } alu_op_t;

  // ---------------------------------------------------------------------
  // instruction word, two views of the same 32 bits
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [5:0]            op;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [4:0]            shamt;
    logic [5:0]            funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]            op;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [15:0]           imm16;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } instr_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;   // load result goes back
    logic    mem_write;
    logic    alu_src_imm;
    logic    reg_dst_rd;   // r-type writes rd, others rt
    logic    sign_ext;
    logic    imm_upper;    // lui
    alu_op_t alu_op;
  } ctrl_t;

  // ---------------------------------------------------------------------
  // pipeline registers, all zero is a bubble
  // ---------------------------------------------------------------------
  typedef struct packed {
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    logic [15:0]           imm;  // raw, shaped in execute
  } id_ex_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic                  mem_write;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       alu_result;  // also the data address
    logic [xlen-1:0]       store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       load_data;
  } mem_wb_t;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_from_mem,
    fwd_from_wb
  } fwd_sel_t;

endpackage
